//--- all.f
logic/poly_pkg.sv
logic/core_pkg.sv
logic/pos_if.sv
logic/pass_sequencer.sv
logic/mul_lane.sv
logic/mod_accumulator.sv
logic/sparse_mul.sv
dv/sparse_mul_sva.sv
dv/tb_sparse_mul.sv

//--- Makefile
TOP = tb_sparse_mul

sim:
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep -qx '=== PASS ==='

clean:
	rm -rf obj_dir

.PHONY: sim clean

//--- dv/tb_sparse_mul.sv
// tb_sparse_mul: table-driven runs of the sparse multiplier against a negacyclic reference model
`timescale 1ns/100ps
`default_nettype none

module tb_sparse_mul;
  import poly_pkg::*;
  import core_pkg::*;

  localparam int RESET_CYCLES = 16;
  localparam int NUM_ROWS     = 5;

  localparam int FILL_DELTA  = 0;
  localparam int FILL_ONES   = 1;
  localparam int FILL_RANDOM = 2;
  localparam int POS_LOW     = 0;
  localparam int POS_HIGH    = 1;
  localparam int POS_RANDOM  = 2;

  // cycle budgets, a run is PASSES passes of N/2 columns plus pipeline fill
  localparam int RUN_LIMIT       = PASSES * (N/2 + 16) * 2;
  localparam int ROW_CYCLES      = N + PASSES + RUN_LIMIT + N/2 + 16;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + 16 + NUM_ROWS * ROW_CYCLES;

  // --------------------------------------------------
  // test table
  // --------------------------------------------------
  string row_name [NUM_ROWS] = '{"delta_low", "ones_wrap", "random_a", "random_b", "delta_wrap"};
  int    row_fill [NUM_ROWS] = '{FILL_DELTA, FILL_ONES, FILL_RANDOM, FILL_RANDOM, FILL_DELTA};
  int    row_pos  [NUM_ROWS] = '{POS_LOW, POS_HIGH, POS_RANDOM, POS_RANDOM, POS_HIGH};

  logic                               clk = 1'b0;
  logic                               reset;
  logic                               start;
  logic                               busy;
  logic                               done;
  logic                               poly_wr_en;
  logic [POLY_ADDR_WIDTH-1:0]         poly_wr_addr;
  logic [PAIR_WIDTH-1:0]              poly_wr_data;
  logic                               pos_wr_en;
  logic [PASS_WIDTH-1:0]              pos_wr_addr;
  logic [CORE_NUM*POS_WIDTH-1:0]      pos_wr_data;
  logic                               res_rd_en;
  logic [RES_ADDR_WIDTH-1:0]          res_rd_addr;
  logic [PAIR_WIDTH-1:0]              res_rd_data;

  int          poly_c [N];
  int          pos_v [H];
  int          exp_c [N];
  logic [15:0] lfsr = 16'd44;
  int          checks = 0;
  int          value_errors = 0;
  int          other_errors = 0;
  int          done_pulses = 0;

  sparse_mul u_dut (
    .clk          (clk),
    .reset        (reset),
    .start        (start),
    .busy         (busy),
    .done         (done),
    .poly_wr_en   (poly_wr_en),
    .poly_wr_addr (poly_wr_addr),
    .poly_wr_data (poly_wr_data),
    .pos_wr_en    (pos_wr_en),
    .pos_wr_addr  (pos_wr_addr),
    .pos_wr_data  (pos_wr_data),
    .res_rd_en    (res_rd_en),
    .res_rd_addr  (res_rd_addr),
    .res_rd_data  (res_rd_data)
  );

  always #50 clk = ~clk;

  always @(negedge clk)
  begin
    if (done)
      done_pulses <= done_pulses + 1;
  end

  // 16-bit Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic int rand_bits(input int width);
    int value;
    value = 0;
    for (int b = 0; b < width; b++)
    begin
      lfsr  = lfsr_step(lfsr);
      value = (value << 1) | int'(lfsr[0]);
    end
    return value;
  endfunction

  task automatic fill_dense(input int kind);
    for (int a = 0; a < N; a++)
    begin
      if (kind == FILL_DELTA)
        poly_c[a] = (a == 0) ? 1 : 0;
      else if (kind == FILL_ONES)
        poly_c[a] = 1;
      else
        poly_c[a] = rand_bits(COEFF_WIDTH) % Q;
    end
  endtask

  task automatic fill_positions(input int kind);
    bit used [N];
    int cand;
    for (int a = 0; a < N; a++)
      used[a] = 1'b0;
    for (int j = 0; j < H; j++)
    begin
      if (kind == POS_LOW)
        pos_v[j] = j;
      else if (kind == POS_HIGH)
        pos_v[j] = N - 1 - j;
      else
      begin
        do
          cand = rand_bits(POS_WIDTH);
        while (used[cand]);
        used[cand] = 1'b1;
        pos_v[j] = cand;
      end
    end
  endtask

  // c[k] = sum of s_j * p[(k - pos_j) mod N], sign flips when the index wraps
  task automatic compute_model();
    int acc;
    int term;
    for (int k = 0; k < N; k++)
    begin
      acc = 0;
      for (int j = 0; j < H; j++)
      begin
        term = poly_c[(k - pos_v[j] + N) % N];
        if (k < pos_v[j])
          term = -term;
        if (j >= H/2)
          term = -term;
        acc = acc + term;
      end
      exp_c[k] = ((acc % Q) + Q) % Q;
    end
  endtask

  task automatic load_memories();
    logic [CORE_NUM*POS_WIDTH-1:0] pos_word;
    for (int a = 0; a < N; a++)
    begin
      @(posedge clk);
      poly_wr_en   <= 1'b1;
      poly_wr_addr <= POLY_ADDR_WIDTH'(a);
      poly_wr_data <= {COEFF_WIDTH'(poly_c[(a + 1) % N]), COEFF_WIDTH'(poly_c[a])};
    end
    @(posedge clk);
    poly_wr_en <= 1'b0;
    for (int g = 0; g < PASSES; g++)
    begin
      for (int i = 0; i < CORE_NUM; i++)
        pos_word[i*POS_WIDTH +: POS_WIDTH] = POS_WIDTH'(pos_v[g*CORE_NUM + i]);
      pos_wr_en   <= 1'b1;
      pos_wr_addr <= PASS_WIDTH'(g);
      pos_wr_data <= pos_word;
      @(posedge clk);
    end
    pos_wr_en <= 1'b0;
  endtask

  task automatic check_idle(input int cycles);
    for (int c = 0; c < cycles; c++)
    begin
      @(negedge clk);
      if (busy || done)
      begin
        $display("busy or done went high before any start");
        other_errors++;
      end
    end
  endtask

  task automatic run_multiply(input string name, input int row);
    int cycles;
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    @(negedge clk);
    if (!busy)
    begin
      $display("%s: busy did not rise after start", name);
      other_errors++;
    end
    cycles = 0;
    while (!done && cycles < RUN_LIMIT)
    begin
      @(negedge clk);
      cycles++;
    end
    if (!done)
    begin
      $display("%s: done did not arrive within %0d cycles", name, RUN_LIMIT);
      other_errors++;
    end
    else if (busy)
    begin
      $display("%s: busy still high when done pulsed", name);
      other_errors++;
    end
    @(negedge clk);
    if (done)
    begin
      $display("%s: done stayed high for more than one cycle", name);
      other_errors++;
    end
    if (done_pulses != row + 1)
    begin
      $display("%s: saw %0d done pulses after %0d starts", name, done_pulses, row + 1);
      other_errors++;
    end
  endtask

  // one address per cycle, each word is due two cycles after its request
  task automatic read_and_check(input string name);
    logic [PAIR_WIDTH-1:0] expected;
    for (int w = 0; w < N/2 + 2; w++)
    begin
      @(posedge clk);
      if (w < N/2)
      begin
        res_rd_en   <= 1'b1;
        res_rd_addr <= RES_ADDR_WIDTH'(w);
      end
      else
        res_rd_en <= 1'b0;
      @(negedge clk);
      if (w >= 2)
      begin
        expected = {COEFF_WIDTH'(exp_c[2*(w-2) + 1]), COEFF_WIDTH'(exp_c[2*(w-2)])};
        checks++;
        if (res_rd_data !== expected)
        begin
          $display("[ERROR] %s word %0d: expected %h, actual %h",
                   name, w - 2, expected, res_rd_data);
          value_errors++;
        end
      end
    end
  endtask

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------
  initial
  begin
    reset        = 1'b1;
    start        = 1'b0;
    poly_wr_en   = 1'b0;
    poly_wr_addr = '0;
    poly_wr_data = '0;
    pos_wr_en    = 1'b0;
    pos_wr_addr  = '0;
    pos_wr_data  = '0;
    res_rd_en    = 1'b0;
    res_rd_addr  = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    check_idle(8);
    // rows run back to back with no reset in between
    for (int r = 0; r < NUM_ROWS; r++)
    begin
      fill_dense(row_fill[r]);
      fill_positions(row_pos[r]);
      compute_model();
      load_memories();
      run_multiply(row_name[r], r);
      read_and_check(row_name[r]);
    end
    $display("%0d checks, %0d value errors, %0d other errors",
             checks, value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, the run is hung", WATCHDOG_CYCLES);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire

//--- dv/sparse_mul_sva.sv
// sparse_mul_sva: concurrent checks on the busy and done handshake of the multiplier
`timescale 1ns/100ps
`default_nettype none

module sparse_mul_sva (
  input logic clk,
  input logic reset,
  input logic busy,
  input logic done
);

  // done is a single-cycle pulse
  property done_single;
    @(posedge clk) disable iff (reset) done |=> !done;
  endproperty

  // busy and done change on the same edge at the end of a run
  property busy_ends_on_done;
    @(posedge clk) disable iff (reset) $fell(busy) |-> $rose(done);
  endproperty

  property done_ends_busy;
    @(posedge clk) disable iff (reset) $rose(done) |-> $fell(busy);
  endproperty

  property idle_after_reset;
    @(posedge clk) reset |=> (!busy && !done);
  endproperty

  a_done_single: assert property (done_single)
    else $error("done stayed high for more than one cycle");
  a_busy_ends_on_done: assert property (busy_ends_on_done)
    else $error("busy fell without a done pulse");
  a_done_ends_busy: assert property (done_ends_busy)
    else $error("done rose while busy did not fall");
  a_idle_after_reset: assert property (idle_after_reset)
    else $error("busy or done high after reset");

endmodule

bind sparse_mul sparse_mul_sva u_sva (
  .clk   (clk),
  .reset (reset),
  .busy  (busy),
  .done  (done)
);

`default_nettype wire

//--- logic/sparse_mul.sv
// sparse_mul: sparse ternary by dense polynomial multiplier mod x^N+1 and Q
`timescale 1ns/100ps
`default_nettype none

module sparse_mul (
  input  logic                                              clk,
  input  logic                                              reset,
  input  logic                                              start,
  output logic                                              busy,
  output logic                                              done,
  input  logic                                              poly_wr_en,
  input  logic [core_pkg::POLY_ADDR_WIDTH-1:0]              poly_wr_addr,
  input  logic [core_pkg::PAIR_WIDTH-1:0]                   poly_wr_data,
  input  logic                                              pos_wr_en,
  input  logic [core_pkg::PASS_WIDTH-1:0]                   pos_wr_addr,
  input  logic [core_pkg::CORE_NUM*core_pkg::POS_WIDTH-1:0] pos_wr_data,
  input  logic                                              res_rd_en,
  input  logic [core_pkg::RES_ADDR_WIDTH-1:0]               res_rd_addr,
  output logic [core_pkg::PAIR_WIDTH-1:0]                   res_rd_data
);
  import core_pkg::*;
  import poly_pkg::*;

  pos_if pos_bus ();

  logic [CORE_NUM-1:0][COEFF_WIDTH-1:0] term_lo;
  logic [CORE_NUM-1:0][COEFF_WIDTH-1:0] term_hi;
  logic                                 term_valid;
  logic                                 first_pass;
  logic                                 pass_written;

  pass_sequencer u_seq (
    .clk          (clk),
    .reset        (reset),
    .start        (start),
    .pos_wr_en    (pos_wr_en),
    .pos_wr_addr  (pos_wr_addr),
    .pos_wr_data  (pos_wr_data),
    .busy         (busy),
    .done         (done),
    .pos          (pos_bus.seq),
    .term_valid   (term_valid),
    .first_pass   (first_pass),
    .pass_written (pass_written)
  );

  // every lane keeps its own dense copy and takes one position per pass
  for (genvar i = 0; i < CORE_NUM; i++)
  begin : g_lane
    mul_lane u_lane (
      .clk          (clk),
      .reset        (reset),
      .poly_wr_en   (poly_wr_en),
      .poly_wr_addr (poly_wr_addr),
      .poly_wr_data (poly_wr_data),
      .pos          (pos_bus.lane),
      .lane_pos     (pos_bus.pos_group[i]),
      .term_lo      (term_lo[i]),
      .term_hi      (term_hi[i])
    );
  end

  mod_accumulator u_acc (
    .clk          (clk),
    .reset        (reset),
    .term_lo      (term_lo),
    .term_hi      (term_hi),
    .term_valid   (term_valid),
    .first_pass   (first_pass),
    .res_rd_en    (res_rd_en),
    .res_rd_addr  (res_rd_addr),
    .res_rd_data  (res_rd_data),
    .pass_written (pass_written)
  );

endmodule

`default_nettype wire

//--- logic/mod_accumulator.sv
// modular accumulator: lane sum, reduction mod Q, result RAM and readback
`timescale 1ns/100ps
`default_nettype none

module mod_accumulator (
  input  logic                                                     clk,
  input  logic                                                     reset,
  input  logic [core_pkg::CORE_NUM-1:0][poly_pkg::COEFF_WIDTH-1:0] term_lo,
  input  logic [core_pkg::CORE_NUM-1:0][poly_pkg::COEFF_WIDTH-1:0] term_hi,
  input  logic                                                     term_valid,
  input  logic                                                     first_pass,
  input  logic                                                     res_rd_en,
  input  logic [core_pkg::RES_ADDR_WIDTH-1:0]                      res_rd_addr,
  output logic [core_pkg::PAIR_WIDTH-1:0]                          res_rd_data,
  output logic                                                     pass_written
);
  import core_pkg::*;
  import poly_pkg::*;

  // index 0 is the low coefficient of a pair, 1 the high one
  logic [1:0][CORE_NUM-1:0][COEFF_WIDTH-1:0] terms;
  logic [1:0][SUM_WIDTH-1:0]                 sum_comb;
  logic [1:0][SUM_WIDTH-1:0]                 sum_q;
  logic [1:0][COEFF_WIDTH:0]                 fold_q;
  logic [1:0][COEFF_WIDTH-1:0]               red_q;
  logic [1:0][COEFF_WIDTH-1:0]               old;
  logic [1:0][COEFF_WIDTH:0]                 acc_q;
  logic [1:0][COEFF_WIDTH-1:0]               wr_data;
  // valid of sum_q, fold_q, red_q, acc_q
  logic [3:0]                                stage_valid;
  logic [RES_ADDR_WIDTH-1:0]                 rd_cnt;
  logic [RES_ADDR_WIDTH-1:0]                 wr_addr;
  logic [RES_ADDR_WIDTH-1:0]                 rd_addr;
  logic [PAIR_WIDTH-1:0]                     res_ram [N/2];
  logic [PAIR_WIDTH-1:0]                     ram_q;
  logic                                      rd_pending;

  // high bits come back in scaled by 2^COEFF_WIDTH mod Q
  function automatic logic [COEFF_WIDTH:0] fold(input logic [SUM_WIDTH-1:0] s);
    logic [COEFF_WIDTH:0] hi_part;
    hi_part = (COEFF_WIDTH+1)'(s[SUM_WIDTH-1:COEFF_WIDTH]) * (COEFF_WIDTH+1)'(FOLD_FACTOR);
    return (COEFF_WIDTH+1)'(s[COEFF_WIDTH-1:0]) + hi_part;
  endfunction

  // one conditional subtract, input is below 2Q
  function automatic logic [COEFF_WIDTH-1:0] sub_q(input logic [COEFF_WIDTH:0] x);
    logic [COEFF_WIDTH:0] d;
    d = x - (COEFF_WIDTH+1)'(Q);
    return (x >= (COEFF_WIDTH+1)'(Q)) ? d[COEFF_WIDTH-1:0] : x[COEFF_WIDTH-1:0];
  endfunction

  assign terms   = {term_hi, term_lo};
  assign old     = first_pass ? '0 : ram_q;
  // streaming owns the read port, readback uses it otherwise
  assign rd_addr = stage_valid[1] ? rd_cnt : res_rd_addr;

  always_comb
  begin
    for (int h = 0; h < 2; h++)
    begin
      sum_comb[h] = '0;
      for (int i = 0; i < CORE_NUM; i++)
        sum_comb[h] = sum_comb[h] + SUM_WIDTH'(terms[h][i]);
      wr_data[h] = sub_q(acc_q[h]);
    end
  end

  // --------------------------------------------------
  // datapath: sum, fold, subtract, add old, subtract
  // --------------------------------------------------
  always_ff @(posedge clk)
  begin
    for (int h = 0; h < 2; h++)
    begin
      sum_q[h]  <= sum_comb[h];
      fold_q[h] <= fold(sum_q[h]);
      red_q[h]  <= sub_q(fold_q[h]);
      acc_q[h]  <= (COEFF_WIDTH+1)'(red_q[h]) + (COEFF_WIDTH+1)'(old[h]);
    end
  end

  // result RAM, old value read two stages ahead of the write
  always_ff @(posedge clk)
  begin
    if (stage_valid[3])
      res_ram[wr_addr] <= wr_data;
    if (stage_valid[1] || res_rd_en)
      ram_q <= res_ram[rd_addr];
    if (rd_pending)
      res_rd_data <= ram_q;
  end

  // --------------------------------------------------
  // control
  // --------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      stage_valid  <= '0;
      rd_cnt       <= '0;
      wr_addr      <= '0;
      rd_pending   <= 1'b0;
      pass_written <= 1'b0;
    end
    else
    begin
      stage_valid  <= {stage_valid[2:0], term_valid};
      rd_pending   <= res_rd_en;
      pass_written <= stage_valid[3] && (wr_addr == RES_ADDR_WIDTH'(N/2 - 1));
      // both counters wrap to zero after N/2 words
      if (stage_valid[1])
        rd_cnt <= rd_cnt + 1'b1;
      if (stage_valid[3])
        wr_addr <= wr_addr + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- logic/mul_lane.sv
// multiplier lane: private dense copy, emits the signed negacyclic term pair
`timescale 1ns/100ps
`default_nettype none

module mul_lane (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                poly_wr_en,
  input  logic [core_pkg::POLY_ADDR_WIDTH-1:0] poly_wr_addr,
  input  logic [core_pkg::PAIR_WIDTH-1:0]      poly_wr_data,
  pos_if.lane                                 pos,
  input  logic [core_pkg::POS_WIDTH-1:0]       lane_pos,
  output logic [poly_pkg::COEFF_WIDTH-1:0]     term_lo,
  output logic [poly_pkg::COEFF_WIDTH-1:0]     term_hi
);
  import core_pkg::*;
  import poly_pkg::*;

  // word a = {p[(a+1) mod N], p[a]}
  logic [PAIR_WIDTH-1:0]      poly_ram [N];
  logic [POLY_ADDR_WIDTH-1:0] rd_addr;
  logic [PAIR_WIDTH-1:0]      rd_word;
  logic [POS_WIDTH-1:0]       col_d1;
  logic [POS_WIDTH:0]         col_hi;
  logic [COEFF_WIDTH-1:0]     coeff_lo;
  logic [COEFF_WIDTH-1:0]     coeff_hi;
  logic                       flip_lo;
  logic                       flip_hi;

  // -c mod Q, zero stays zero
  function automatic logic [COEFF_WIDTH-1:0] neg_q(input logic [COEFF_WIDTH-1:0] c);
    return (c == '0) ? '0 : COEFF_WIDTH'(Q) - c;
  endfunction

  assign coeff_lo = rd_word[COEFF_WIDTH-1:0];
  assign coeff_hi = rd_word[PAIR_WIDTH-1:COEFF_WIDTH];
  assign col_hi   = col_d1 + 1'b1;

  // columns before the position wrap around x^N = -1 and change sign
  assign flip_lo = (col_d1 >= lane_pos) != !pos.negate;
  assign flip_hi = (col_hi >= {1'b0, lane_pos}) != !pos.negate;

  // read address walks p[(col - pos) mod N]
  always_ff @(posedge clk)
  begin
    if (reset)
      rd_addr <= '0;
    else if (pos.pos_load)
      // (N - pos) mod N, N wraps to zero in this width
      rd_addr <= POLY_ADDR_WIDTH'(N) - lane_pos;
    else if (pos.col_valid)
      rd_addr <= rd_addr + POLY_ADDR_WIDTH'(2);
  end

  // stage 1: dense RAM read, column travels along
  always_ff @(posedge clk)
  begin
    if (poly_wr_en)
      poly_ram[poly_wr_addr] <= poly_wr_data;
    if (pos.col_valid)
    begin
      rd_word <= poly_ram[rd_addr];
      col_d1  <= pos.col;
    end
  end

  // stage 2: signed term pair
  always_ff @(posedge clk)
  begin
    term_lo <= flip_lo ? neg_q(coeff_lo) : coeff_lo;
    term_hi <= flip_hi ? neg_q(coeff_hi) : coeff_hi;
  end

endmodule

`default_nettype wire

//--- logic/pass_sequencer.sv
// pass sequencer: position RAM, pass and column counters, run start and done
`timescale 1ns/100ps
`default_nettype none

module pass_sequencer (
  input  logic                                              clk,
  input  logic                                              reset,
  input  logic                                              start,
  input  logic                                              pos_wr_en,
  input  logic [core_pkg::PASS_WIDTH-1:0]                   pos_wr_addr,
  input  logic [core_pkg::CORE_NUM*core_pkg::POS_WIDTH-1:0] pos_wr_data,
  output logic                                              busy,
  output logic                                              done,
  pos_if.seq                                                pos,
  output logic                                              term_valid,
  output logic                                              first_pass,
  input  logic                                              pass_written
);
  import core_pkg::*;
  import poly_pkg::*;

  // one word per pass, lane i in bits [i*POS_WIDTH +: POS_WIDTH]
  logic [CORE_NUM-1:0][POS_WIDTH-1:0] pos_ram [PASSES];

  logic [PASS_WIDTH-1:0] pass;
  logic                  pos_rd;
  logic                  last_pass;
  logic                  last_col;
  logic                  col_valid_d1;

  assign last_pass = (pass == PASS_WIDTH'(PASSES - 1));
  assign last_col  = pos.col_valid && (pos.col == POS_WIDTH'(N - 2));

  // the second half of the groups carries the -1 coefficients
  assign pos.negate = (pass >= PASS_WIDTH'(PASSES / 2));
  // result RAM content is stale on the first pass
  assign first_pass = (pass == '0);

  // --------------------------------------------------
  // position RAM
  // --------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (pos_wr_en)
      pos_ram[pos_wr_addr] <= pos_wr_data;
    if (pos_rd)
      pos.pos_group <= pos_ram[pass];
  end

  // --------------------------------------------------
  // run control and column stream
  // --------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      busy          <= 1'b0;
      done          <= 1'b0;
      pass          <= '0;
      pos_rd        <= 1'b0;
      pos.pos_load  <= 1'b0;
      pos.col_valid <= 1'b0;
      pos.col       <= '0;
      col_valid_d1  <= 1'b0;
      term_valid    <= 1'b0;
    end
    else
    begin
      done         <= 1'b0;
      pos_rd       <= 1'b0;
      pos.pos_load <= pos_rd;
      // lane latency of two cycles
      col_valid_d1 <= pos.col_valid;
      term_valid   <= col_valid_d1;

      if (start && !busy)
      begin
        busy   <= 1'b1;
        pass   <= '0;
        pos_rd <= 1'b1;
      end
      else if (pass_written)
      begin
        // next pass reads what this one wrote, so it waits for the write
        if (last_pass)
        begin
          busy <= 1'b0;
          done <= 1'b1;
        end
        else
        begin
          pass   <= pass + 1'b1;
          pos_rd <= 1'b1;
        end
      end

      // columns start the cycle after pos_load
      if (pos.pos_load)
      begin
        pos.col_valid <= 1'b1;
        pos.col       <= '0;
      end
      else if (pos.col_valid)
      begin
        pos.col <= pos.col + POS_WIDTH'(2);
        if (last_col)
          pos.col_valid <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/pos_if.sv
// pos_if: positions and column control from the pass sequencer to the lanes
`timescale 1ns/100ps
`default_nettype none

interface pos_if;
  import core_pkg::*;

  // one pulse per pass, pos_group holds from here until the next pass
  logic                               pos_load;
  // element i belongs to lane i
  logic [CORE_NUM-1:0][POS_WIDTH-1:0] pos_group;
  // high for the -1 half of the sparse positions
  logic                               negate;
  // N/2 back-to-back cycles per pass
  logic                               col_valid;
  // even column index of the pair being produced
  logic [POS_WIDTH-1:0]               col;

  modport seq (output pos_load, pos_group, negate, col_valid, col);

  modport lane (input pos_load, pos_group, negate, col_valid, col);

endinterface

`default_nettype wire

//--- logic/core_pkg.sv
// core_pkg: hardware layout of the sparse multiplier, lanes, passes and widths
`default_nettype none

package core_pkg;

  // parallel lanes, each one handles one sparse position per pass
  localparam int CORE_NUM = 4;

  // one pass per group of CORE_NUM positions
  localparam int PASSES = poly_pkg::H / CORE_NUM;

  localparam int POS_WIDTH       = $clog2(poly_pkg::N);
  localparam int PAIR_WIDTH      = 2 * poly_pkg::COEFF_WIDTH;
  localparam int POLY_ADDR_WIDTH = $clog2(poly_pkg::N);
  // result RAM holds two coefficients per word
  localparam int RES_ADDR_WIDTH  = $clog2(poly_pkg::N / 2);
  localparam int PASS_WIDTH      = $clog2(PASSES);

  // room for the sum of CORE_NUM reduced coefficients
  localparam int SUM_WIDTH = poly_pkg::COEFF_WIDTH + $clog2(CORE_NUM);

endpackage

`default_nettype wire

//--- logic/poly_pkg.sv
// poly_pkg: ring constants of the LAC polynomial arithmetic, Z_Q[x]/(x^N+1)
`default_nettype none

package poly_pkg;

  // coefficient modulus
  localparam int Q = 251;

  // polynomial length, the ring is taken modulo x^N+1
  localparam int N = 64;

  // nonzero coefficients of the sparse operand
  // the first H/2 are +1, the rest are -1
  localparam int H = 16;

  localparam int COEFF_WIDTH = 8;

  // 2^COEFF_WIDTH mod Q, weight of the bits folded down from a wide sum
  localparam int FOLD_FACTOR = (1 << COEFF_WIDTH) % Q;

endpackage

`default_nettype wire
